/* io_mem.f */
+incdir+src
src/io_mem_pkg.sv
src/io_check.sv
src/io_access.sv
src/data_ram.sv
src/io_response.sv
src/io_mem_top.sv
tb/io_mem_assertions.sv
tb/io_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the io_mem testbench with Verilator.
# The exit status is 0 only when the run prints the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module io_mem_tb \
    -f io_mem.f -o io_mem_sim || exit 1
out=$(./obj_dir/io_mem_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1

/* tb/io_mem_tb.sv */
////////////////////
// Testbench for io_mem_top. The bound assertion module does the checking.
// Memory is filled first so that every later read has a known word.
////////////////////

`include "io_mem_defines.svh"

module io_mem_tb;

    import io_mem_pkg::*;

    localparam int num_random = 240;
    // One cycle per slot for idles, memory fill, directed and random accesses.
    localparam int num_slots       = 3 + `IO_MEM_DEPTH + 4 + num_random;
    localparam int watchdog_cycles = 8 + num_slots + 20;

    logic                                                  clock;
    logic                                                  rst;
    logic                                                  req_valid;
    mem_req_t                                              req;
    logic [`IO_MEM_PORT_COUNT-1:0]                         rd_port_ef;
    logic [`IO_MEM_PORT_COUNT-1:0][`IO_MEM_WORD_WIDTH-1:0] rd_port_data;
    logic [`IO_MEM_PORT_COUNT-1:0]                         wr_port_ef;
    logic                                                  rsp_valid;
    mem_rsp_t                                              rsp;
    logic [`IO_MEM_PORT_COUNT-1:0]                         rd_port_pop;
    logic [`IO_MEM_PORT_COUNT-1:0]                         wr_port_push;
    logic [`IO_MEM_WORD_WIDTH-1:0]                         wr_port_data;
    int unsigned                                           req_count;
    int unsigned                                           rsp_count;
    int unsigned                                           total_errors;

    io_mem_top io_mem_top_inst (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    always @(posedge clock) begin
        if (rst) begin
            rsp_count <= 0;
        end else if (rsp_valid) begin
            rsp_count <= rsp_count + 1;
        end
    end

    // One request for one cycle with the port flags held alongside it.
    task automatic send(input mem_op_e op, input logic [`IO_MEM_ADDR_WIDTH-1:0] addr,
                        input logic [`IO_MEM_WORD_WIDTH-1:0] wdata,
                        input logic [`IO_MEM_PORT_COUNT-1:0] rd_ef,
                        input logic [`IO_MEM_PORT_COUNT-1:0] wr_ef);
        req_valid  = 1'b1;
        req        = {op, addr, wdata};
        rd_port_ef = rd_ef;
        wr_port_ef = wr_ef;
        req_count  = req_count + 1;
        @(posedge clock);
        #10;
    endtask

    task automatic idle_cycle();
        req_valid = 1'b0;
        @(posedge clock);
        #10;
    endtask

    // Half of the addresses land on F0 to F7 around the port block.
    task automatic random_request();
        logic [31:0]                   rnd;
        logic [31:0]                   dat;
        logic [`IO_MEM_ADDR_WIDTH-1:0] addr;
        rnd  = $urandom;
        dat  = $urandom;
        addr = rnd[0] ? (`IO_MEM_PORT_BASE | {5'b0, rnd[3:1]}) : rnd[11:4];
        send(rnd[12] ? OP_WRITE : OP_READ, addr, dat[15:0], rnd[16:13], rnd[20:17]);
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(32'h2f51_4ac9));
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        rd_port_ef = '0;
        wr_port_ef = '0;
        req_count  = 0;
        // Each read port holds its own constant word.
        for (int p = 0; p < `IO_MEM_PORT_COUNT; p++) begin
            rd_port_data[p] = {4'hD, p[3:0], 4'h5, p[3:0]};
        end
        repeat (8) @(posedge clock);
        #10;
        rst = 1'b0;
        repeat (3) idle_cycle();
        for (int i = 0; i < `IO_MEM_DEPTH; i++) begin
            rnd = $urandom;
            send(OP_WRITE, i[`IO_MEM_ADDR_WIDTH-1:0], rnd[15:0], rnd[19:16], rnd[23:20]);
        end
        // Write then read back to back, directly and through a wrapped address.
        // Every port reads as not ready, which a memory access ignores.
        send(OP_WRITE, 8'h15, 16'h1234, '0, '1);
        send(OP_READ, 8'h15, 16'h0000, '0, '1);
        send(OP_WRITE, 8'h95, 16'hBEEF, '0, '1);
        send(OP_READ, 8'hD5, 16'h0000, '0, '1);
        for (int i = 0; i < num_random; i++) begin
            if ($urandom % 8 == 0) begin
                idle_cycle();
            end else begin
                random_request();
            end
        end
        req_valid = 1'b0;
        while (rsp_count != req_count) begin
            @(posedge clock);
            #10;
        end
        total_errors = io_mem_top_inst.io_mem_assertions_inst.error_count;
        $display("Requests %0d, responses %0d, errors %0d", req_count, rsp_count, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * 100);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* tb/io_mem_assertions.sv */
////////////////////
// Checks on io_mem_top against the port rules and a shadow memory.
// Memory reads are only predicted for words written after reset.
////////////////////

`include "io_mem_defines.svh"

module io_mem_assertions (
    input logic                                                   clock,
    input logic                                                   rst,
    input logic                                                   req_valid,
    input io_mem_pkg::mem_req_t                                   req,
    input logic [`IO_MEM_PORT_COUNT-1:0]                          rd_port_ef,
    input logic [`IO_MEM_PORT_COUNT-1:0][`IO_MEM_WORD_WIDTH-1:0]  rd_port_data,
    input logic [`IO_MEM_PORT_COUNT-1:0]                          wr_port_ef,
    input logic                                                   rsp_valid,
    input io_mem_pkg::mem_rsp_t                                   rsp,
    input logic [`IO_MEM_PORT_COUNT-1:0]                          rd_port_pop,
    input logic [`IO_MEM_PORT_COUNT-1:0]                          wr_port_push,
    input logic [`IO_MEM_WORD_WIDTH-1:0]                          wr_port_data
);

    import io_mem_pkg::*;

    localparam int depth_bits = $clog2(`IO_MEM_DEPTH);
    localparam int sel_bits   = $clog2(`IO_MEM_PORT_COUNT);

    // Request together with the port flags sampled on the same edge.
    typedef struct packed {
        logic                          valid;
        mem_req_t                      req;
        logic [`IO_MEM_PORT_COUNT-1:0] rd_ef;
        logic [`IO_MEM_PORT_COUNT-1:0] wr_ef;
    } stage_t;

    int unsigned                                           error_count = 0;
    logic [`IO_MEM_WORD_WIDTH-1:0]                         shadow [0:`IO_MEM_DEPTH-1];
    stage_t                                                s1;
    stage_t                                                s2;
    logic [`IO_MEM_PORT_COUNT-1:0][`IO_MEM_WORD_WIDTH-1:0] port_data;
    logic [sel_bits-1:0]                                   port;
    mem_rsp_t                                              exp_rsp;
    logic [`IO_MEM_PORT_COUNT-1:0]                         exp_pop;
    logic [`IO_MEM_PORT_COUNT-1:0]                         exp_push;

    function automatic logic is_port_addr(input logic [`IO_MEM_ADDR_WIDTH-1:0] addr);
        return (addr >= `IO_MEM_PORT_BASE) && (addr < `IO_MEM_PORT_BASE + `IO_MEM_PORT_COUNT);
    endfunction

    task automatic report_failure(input string msg);
        error_count++;
        $error("%s", msg);
    endtask

    // s1 holds a request during its cycle 1, s2 during its cycle 2.
    always_ff @(posedge clock) begin
        s1        <= {req_valid && !rst, req, rd_port_ef, wr_port_ef};
        s2        <= s1;
        s2.valid  <= s1.valid && !rst;
        port_data <= rd_port_data;
    end

    // Shadow copy commits with the RAM, at the edge ending cycle 1.
    always_ff @(posedge clock) begin
        if (s1.valid && !is_port_addr(s1.req.addr) && (s1.req.op == OP_WRITE)) begin
            shadow[s1.req.addr[depth_bits-1:0]] <= s1.req.wdata;
        end
    end

    always_comb begin
        port             = s2.req.addr[sel_bits-1:0];
        exp_rsp.op       = s2.req.op;
        exp_rsp.is_io    = is_port_addr(s2.req.addr);
        exp_rsp.annulled = 1'b0;
        exp_rsp.rdata    = '0;
        exp_pop          = '0;
        exp_push         = '0;
        if (!exp_rsp.is_io && (s2.req.op == OP_READ)) begin
            exp_rsp.rdata = shadow[s2.req.addr[depth_bits-1:0]];
        end else if (exp_rsp.is_io && (s2.req.op == OP_READ)) begin
            // Read port is ready only while it holds data.
            exp_rsp.annulled = (s2.rd_ef[port] != `IO_MEM_EF_FULL);
            exp_rsp.rdata    = exp_rsp.annulled ? '0 : port_data[port];
            exp_pop[port]    = s2.valid && !exp_rsp.annulled;
        end else if (exp_rsp.is_io) begin
            exp_rsp.annulled = (s2.wr_ef[port] != `IO_MEM_EF_EMPTY);
            exp_push[port]   = s2.valid && !exp_rsp.annulled;
        end
    end

    rsp_latency: assert property (@(posedge clock) disable iff (rst) rsp_valid == s2.valid)
        else report_failure($sformatf("Mismatch rsp_valid: got %h expected %h",
            $sampled(rsp_valid), $sampled(s2.valid)));

    port_strobes: assert property (@(posedge clock) disable iff (rst)
        (rd_port_pop == exp_pop) && (wr_port_push == exp_push))
        else report_failure($sformatf("Mismatch rd_port_pop/wr_port_push: got %h/%h expected %h/%h",
            $sampled(rd_port_pop), $sampled(wr_port_push), $sampled(exp_pop), $sampled(exp_push)));

    rsp_fields: assert property (@(posedge clock) disable iff (rst) s2.valid |-> rsp == exp_rsp)
        else report_failure($sformatf("Mismatch rsp: got %h expected %h",
            $sampled(rsp), $sampled(exp_rsp)));

    push_data: assert property (@(posedge clock) disable iff (rst)
        (|exp_push) |-> wr_port_data == s2.req.wdata)
        else report_failure($sformatf("Mismatch wr_port_data: got %h expected %h",
            $sampled(wr_port_data), $sampled(s2.req.wdata)));

endmodule

bind io_mem_top io_mem_assertions io_mem_assertions_inst (.*);

/* src/io_mem_top.sv */
////////////////////
// Data memory with memory-mapped I/O ports, fixed two-cycle latency.
// One request per cycle, no back-pressure; annulled accesses are not retried.
////////////////////

`include "io_mem_defines.svh"

module io_mem_top (
    input  logic                                                    clock,
    input  logic                                                    rst,
    input  logic                                                    req_valid,
    input  io_mem_pkg::mem_req_t                                    req,
    input  logic [`IO_MEM_PORT_COUNT-1:0]                           rd_port_ef,
    input  logic [`IO_MEM_PORT_COUNT-1:0][`IO_MEM_WORD_WIDTH-1:0]   rd_port_data,
    input  logic [`IO_MEM_PORT_COUNT-1:0]                           wr_port_ef,
    output logic                                                    rsp_valid,
    output io_mem_pkg::mem_rsp_t                                    rsp,
    output logic [`IO_MEM_PORT_COUNT-1:0]                           rd_port_pop,
    output logic [`IO_MEM_PORT_COUNT-1:0]                           wr_port_push,
    output logic [`IO_MEM_WORD_WIDTH-1:0]                           wr_port_data
);

    import io_mem_pkg::*;

    logic                          acc_valid;
    mem_req_t                      acc_req;
    logic                          acc_is_io;
    logic                          acc_accept;
    logic                          ram_wr_en;
    logic [`IO_MEM_WORD_WIDTH-1:0] ram_rdata;

    io_access io_access_inst (
        .clock      (clock),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .rd_port_ef (rd_port_ef),
        .wr_port_ef (wr_port_ef),
        .acc_valid  (acc_valid),
        .acc_req    (acc_req),
        .acc_is_io  (acc_is_io),
        .acc_accept (acc_accept)
    );

    // Memory writes commit at the end of the decision cycle.
    assign ram_wr_en = acc_valid && acc_accept && !acc_is_io && (acc_req.op == OP_WRITE);

    data_ram data_ram_inst (
        .clock  (clock),
        .wr_en  (ram_wr_en),
        .addr   (acc_req.addr[$clog2(`IO_MEM_DEPTH)-1:0]),
        .wdata  (acc_req.wdata),
        .rdata  (ram_rdata)
    );

    io_response io_response_inst (
        .clock        (clock),
        .rst          (rst),
        .acc_valid    (acc_valid),
        .acc_req      (acc_req),
        .acc_is_io    (acc_is_io),
        .acc_accept   (acc_accept),
        .ram_rdata    (ram_rdata),
        .rd_port_data (rd_port_data),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rd_port_pop  (rd_port_pop),
        .wr_port_push (wr_port_push),
        .wr_port_data (wr_port_data)
    );

endmodule

/* src/io_response.sv */
////////////////////
// Response stage. Drives port strobes and builds the response word.
// All outputs are valid in the cycle after acc_valid, for one cycle.
////////////////////

`include "io_mem_defines.svh"

module io_response (
    input  logic                                                    clock,
    input  logic                                                    rst,
    input  logic                                                    acc_valid,
    input  io_mem_pkg::mem_req_t                                    acc_req,
    input  logic                                                    acc_is_io,
    input  logic                                                    acc_accept,
    input  logic [`IO_MEM_WORD_WIDTH-1:0]                           ram_rdata,
    input  logic [`IO_MEM_PORT_COUNT-1:0][`IO_MEM_WORD_WIDTH-1:0]   rd_port_data,
    output logic                                                    rsp_valid,
    output io_mem_pkg::mem_rsp_t                                    rsp,
    output logic [`IO_MEM_PORT_COUNT-1:0]                           rd_port_pop,
    output logic [`IO_MEM_PORT_COUNT-1:0]                           wr_port_push,
    output logic [`IO_MEM_WORD_WIDTH-1:0]                           wr_port_data
);

    import io_mem_pkg::*;

    localparam int sel_width = $clog2(`IO_MEM_PORT_COUNT);

    logic [`IO_MEM_ADDR_WIDTH-1:0] addr_offset;
    logic [sel_width-1:0]          port_sel;
    logic [`IO_MEM_PORT_COUNT-1:0] port_onehot;
    logic                          io_rd_go;
    logic                          io_wr_go;
    mem_rsp_t                      rsp_reg;
    logic                          use_ram_reg;

    assign addr_offset = acc_req.addr - `IO_MEM_PORT_BASE;
    assign port_sel    = addr_offset[sel_width-1:0];

    always_comb begin
        port_onehot           = '0;
        port_onehot[port_sel] = 1'b1;
    end

    // Only accepted I/O accesses touch a port.
    assign io_rd_go = acc_valid && acc_is_io && acc_accept && (acc_req.op == OP_READ);
    assign io_wr_go = acc_valid && acc_is_io && acc_accept && (acc_req.op == OP_WRITE);

    always_ff @(posedge clock) begin
        if (rst) begin
            rsp_valid    <= 1'b0;
            rd_port_pop  <= '0;
            wr_port_push <= '0;
        end else begin
            rsp_valid    <= acc_valid;
            rd_port_pop  <= io_rd_go ? port_onehot : '0;
            wr_port_push <= io_wr_go ? port_onehot : '0;
        end
    end

    // Port read data is sampled here; RAM data arrives on its own register.
    always_ff @(posedge clock) begin
        rsp_reg.op       <= acc_req.op;
        rsp_reg.is_io    <= acc_is_io;
        rsp_reg.annulled <= !acc_accept;
        rsp_reg.rdata    <= io_rd_go ? rd_port_data[port_sel] : '0;
        use_ram_reg      <= !acc_is_io && (acc_req.op == OP_READ);
        wr_port_data     <= acc_req.wdata;
    end

    always_comb begin
        rsp = rsp_reg;
        if (use_ram_reg) begin
            rsp.rdata = ram_rdata;
        end
    end

endmodule

/* src/data_ram.sv */
////////////////////
// Data memory with one write port and one registered read.
// Read during write to the same word returns the old word.
////////////////////

`include "io_mem_defines.svh"

module data_ram (
    input  logic                                clock,
    input  logic                                wr_en,
    input  logic [$clog2(`IO_MEM_DEPTH)-1:0]    addr,
    input  logic [`IO_MEM_WORD_WIDTH-1:0]       wdata,
    output logic [`IO_MEM_WORD_WIDTH-1:0]       rdata
);

    logic [`IO_MEM_WORD_WIDTH-1:0] mem [0:`IO_MEM_DEPTH-1];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end
    end

    // Read every cycle. The consumer decides whether the word is used.
    always_ff @(posedge clock) begin
        rdata <= mem[addr];
    end

endmodule

/* src/io_access.sv */
////////////////////
// Access checker. Registers the request and decides accept or annul.
// acc_accept and acc_is_io are only meaningful while acc_valid is high.
////////////////////

`include "io_mem_defines.svh"

module io_access (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            req_valid,
    input  io_mem_pkg::mem_req_t            req,
    input  logic [`IO_MEM_PORT_COUNT-1:0]   rd_port_ef,
    input  logic [`IO_MEM_PORT_COUNT-1:0]   wr_port_ef,
    output logic                            acc_valid,
    output io_mem_pkg::mem_req_t            acc_req,
    output logic                            acc_is_io,
    output logic                            acc_accept
);

    import io_mem_pkg::*;

    // A read port holds data when FULL, a write port has room when EMPTY.
    localparam logic rd_ready = `IO_MEM_EF_FULL;
    localparam logic wr_ready = `IO_MEM_EF_EMPTY;

    logic rd_ef_masked;
    logic rd_is_io;
    logic wr_ef_masked;
    logic wr_is_io;

    io_check #(
        .ready_state    (rd_ready)
    ) rd_check (
        .clock          (clock),
        .addr           (req.addr),
        .port_ef        (rd_port_ef),
        .port_ef_masked (rd_ef_masked),
        .addr_is_io     (rd_is_io)
    );

    io_check #(
        .ready_state    (wr_ready)
    ) wr_check (
        .clock          (clock),
        .addr           (req.addr),
        .port_ef        (wr_port_ef),
        .port_ef_masked (wr_ef_masked),
        .addr_is_io     (wr_is_io)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= req_valid;
        end
    end

    // Request payload lines up with the io_check outputs.
    always_ff @(posedge clock) begin
        acc_req <= req;
    end

    // The op picks which port bank is checked.
    // Memory addresses come back masked to ready, so they always pass.
    always_comb begin
        if (acc_req.op == OP_WRITE) begin
            acc_is_io  = wr_is_io;
            acc_accept = (wr_ef_masked == wr_ready);
        end else begin
            acc_is_io  = rd_is_io;
            acc_accept = (rd_ef_masked == rd_ready);
        end
    end

endmodule

/* src/io_check.sv */
////////////////////
// Registered I/O address decode with Empty/Full selection.
// Outputs are valid one cycle after addr and port_ef are sampled.
////////////////////

`include "io_mem_defines.svh"

module io_check #(
    // Bit value reported for ordinary memory addresses.
    parameter logic ready_state = `IO_MEM_EF_FULL
) (
    input  logic                            clock,
    input  logic [`IO_MEM_ADDR_WIDTH-1:0]   addr,
    input  logic [`IO_MEM_PORT_COUNT-1:0]   port_ef,
    output logic                            port_ef_masked,
    output logic                            addr_is_io
);

    localparam int sel_width = $clog2(`IO_MEM_PORT_COUNT);

    logic [`IO_MEM_ADDR_WIDTH-1:0] addr_offset;
    logic [sel_width-1:0]          port_sel;
    logic                          hit;
    logic                          is_io_reg;
    logic                          ef_sel_reg;

    // Offset into the port block. Only meaningful when hit is set.
    assign addr_offset = addr - `IO_MEM_PORT_BASE;
    assign port_sel    = addr_offset[sel_width-1:0];

    assign hit = (addr >= `IO_MEM_PORT_BASE) &&
                 (addr < (`IO_MEM_PORT_BASE + `IO_MEM_PORT_COUNT));

    // Decode and selected bit are captured on the same edge.
    always_ff @(posedge clock) begin
        is_io_reg  <= hit;
        ef_sel_reg <= port_ef[port_sel];
    end

    assign addr_is_io = is_io_reg;

    // Memory is always ready, so non-I/O addresses report ready_state.
    assign port_ef_masked = is_io_reg ? ef_sel_reg : ready_state;

endmodule

/* src/io_mem_pkg.sv */
////////////////////
// Request and response types.
// Field order is fixed; the testbench builds requests from it.
////////////////////

`include "io_mem_defines.svh"

package io_mem_pkg;

    // Access operation.
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // 25-bit request as presented with req_valid.
    typedef struct packed {
        mem_op_e                         op;
        logic [`IO_MEM_ADDR_WIDTH-1:0]   addr;
        logic [`IO_MEM_WORD_WIDTH-1:0]   wdata;
    } mem_req_t;

    // 19-bit response as presented with rsp_valid.
    // rdata is zero for writes and for annulled reads.
    typedef struct packed {
        mem_op_e                         op;
        logic                            is_io;
        logic                            annulled;
        logic [`IO_MEM_WORD_WIDTH-1:0]   rdata;
    } mem_rsp_t;

endpackage

/* src/io_mem_defines.svh */
////////////////////
// Widths, memory depth and I/O port map shared by the whole design.
// The port block must start on a PORT_COUNT-aligned address.
////////////////////

`ifndef IO_MEM_DEFINES_SVH
`define IO_MEM_DEFINES_SVH

// Request address and data word widths.
`define IO_MEM_ADDR_WIDTH 8
`define IO_MEM_WORD_WIDTH 16

// Memory words. Non-I/O addresses wrap onto this by their low bits.
`define IO_MEM_DEPTH 64

// I/O block. Read port N and write port N share address BASE+N.
`define IO_MEM_PORT_BASE 8'hF0
`define IO_MEM_PORT_COUNT 4

// Empty/Full bit encoding.
// A read port is ready when FULL, a write port when EMPTY.
`define IO_MEM_EF_FULL 1'b1
`define IO_MEM_EF_EMPTY 1'b0

`endif
